// ==== design/wb_commit.sv ====
module wb_commit (
    input  logic               enable,
    input  wb_pkg::wb_bundle_t wb,
    input  logic [63:0]        csr_rdata,
    output wb_pkg::csr_req_t   csr_req,
    output wb_pkg::commit_t    commit_out
);

    import wb_pkg::*;

    logic        retire;
    logic        is_csr;
    logic        is_imm_form;
    logic        no_trap;
    logic [63:0] wb_data;

    // the instruction leaves the stage at this edge, so it is counted here only.
    assign retire  = wb.valid && enable;
    assign no_trap = (wb.trap == TRAP_NOP);

    assign is_csr = wb.ctrl inside {WB_CSRRW, WB_CSRRS, WB_CSRRC,
                                    WB_CSRRWI, WB_CSRRSI, WB_CSRRCI};

    assign is_imm_form = wb.ctrl inside {WB_CSRRWI, WB_CSRRSI, WB_CSRRCI};

    always_comb begin
        case (wb.ctrl)
            WB_EXE:  wb_data = wb.exe;
            WB_MEM:  wb_data = wb.mem;
            WB_IMM:  wb_data = wb.imm;
            WB_PC4:  wb_data = wb.pc + 64'd4;
            WB_CSRRW, WB_CSRRS, WB_CSRRC,
            WB_CSRRWI, WB_CSRRSI, WB_CSRRCI: begin
                wb_data = csr_rdata; // old csr value goes to rd.
            end
            default: wb_data = 64'd0;
        endcase
    end

    always_comb begin
        csr_req.addr = wb.csr;
        csr_req.pc   = wb.pc;
        csr_req.operand = is_imm_form ? wb.zimm : wb.exe;
        // a trapping instruction never touches a csr through the op path.
        if (retire && no_trap && is_csr) begin
            csr_req.op = wb.ctrl;
        end else begin
            csr_req.op = WB_NOP;
        end
        csr_req.trap = retire ? wb.trap : TRAP_NOP;
    end

    always_comb begin
        commit_out.rd   = wb.rd;
        commit_out.data = wb_data;
        commit_out.we   = retire && no_trap && (wb.ctrl != WB_NOP) && (wb.rd != 5'd0);
    end

endmodule

// ==== design/wb_csr_file.sv ====
module wb_csr_file #(
    parameter logic [63:0] MTVEC_RESET = 64'h0000_0000_8000_0100
) (
    input  logic              clk,
    input  logic              rst,
    input  wb_pkg::csr_req_t  req,
    output logic [63:0]       rdata,
    output wb_pkg::redirect_t redirect
);

    import wb_pkg::*;

    logic [63:0] mstatus;
    logic [63:0] mtvec;
    logic [63:0] mepc;
    logic [63:0] mcause;
    logic [63:0] mscratch;

    logic [63:0] csr_old;
    logic [63:0] csr_new;
    logic        csr_hit;
    logic        csr_wen;
    logic        trap_entry;

    always_comb begin
        csr_old = 64'd0;
        csr_hit = 1'b1;
        case (req.addr)
            CSR_MSTATUS:  csr_old = mstatus;
            CSR_MTVEC:    csr_old = mtvec;
            CSR_MEPC:     csr_old = mepc;
            CSR_MCAUSE:   csr_old = mcause;
            CSR_MSCRATCH: csr_old = mscratch;
            default:      csr_hit = 1'b0; // unimplemented, reads as zero.
        endcase
    end

    assign rdata = csr_old;

    // set and clear with nothing to set or clear leave the csr alone.
    always_comb begin
        csr_new = csr_old;
        csr_wen = 1'b0;
        case (req.op)
            WB_CSRRW, WB_CSRRWI: begin
                csr_new = req.operand;
                csr_wen = csr_hit;
            end
            WB_CSRRS, WB_CSRRSI: begin
                csr_new = csr_old | req.operand;
                csr_wen = csr_hit && (req.operand != 64'd0);
            end
            WB_CSRRC, WB_CSRRCI: begin
                csr_new = csr_old & ~req.operand;
                csr_wen = csr_hit && (req.operand != 64'd0);
            end
            default: begin
                csr_wen = 1'b0;
            end
        endcase
    end

    assign trap_entry = (req.trap == TRAP_ECALL) || (req.trap == TRAP_EBREAK);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mstatus  <= 64'd0;
            mtvec    <= MTVEC_RESET;
            mepc     <= 64'd0;
            mcause   <= 64'd0;
            mscratch <= 64'd0;
        end else begin
            if (csr_wen) begin
                case (req.addr)
                    CSR_MSTATUS:  mstatus  <= csr_new;
                    CSR_MTVEC:    mtvec    <= csr_new;
                    CSR_MEPC:     mepc     <= csr_new;
                    CSR_MCAUSE:   mcause   <= csr_new;
                    CSR_MSCRATCH: mscratch <= csr_new;
                    default: ;
                endcase
            end
            if (trap_entry) begin
                mepc   <= req.pc;
                mcause <= (req.trap == TRAP_ECALL) ? CAUSE_ECALL_M : CAUSE_BREAKPOINT;
            end
        end
    end

    // trap entry jumps to the handler base, mret returns to the saved pc.
    assign redirect.valid = (req.trap != TRAP_NOP);
    assign redirect.pc    = (req.trap == TRAP_MRET) ? mepc : mtvec;

    // the commit unit must never issue a trap and a csr op together.
    a_trap_excludes_op : assert property (
        @(posedge clk) disable iff (rst) (req.trap != TRAP_NOP) |-> (req.op == WB_NOP)
    ) else $error("wb_csr_file: trap issued together with a csr op");

endmodule

// ==== design/wb_pkg.sv ====
package wb_pkg;

    // writeback source selected by the decoder.
    typedef enum logic [3:0] {
        WB_NOP,
        WB_EXE,
        WB_MEM,
        WB_IMM,
        WB_PC4,
        WB_CSRRW,
        WB_CSRRS,
        WB_CSRRC,
        WB_CSRRWI,
        WB_CSRRSI,
        WB_CSRRCI
    } wb_ctrl_e;

    typedef enum logic [3:0] {
        TRAP_NOP,
        TRAP_ECALL,
        TRAP_EBREAK,
        TRAP_MRET
    } trap_e;

    // everything the memory stage hands over to writeback.
    typedef struct packed {
        logic        valid;
        trap_e       trap;
        logic [63:0] exe;  // alu result, also the rs1 value for csr ops.
        logic [63:0] mem;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [11:0] csr;
        logic [63:0] imm;
        logic [63:0] zimm;
        logic [63:0] pc;
        wb_ctrl_e    ctrl;
    } wb_bundle_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  rd;
        logic [63:0] data;
    } commit_t;

    typedef struct packed {
        logic        valid;
        logic [63:0] pc;
    } redirect_t;

    typedef struct packed {
        wb_ctrl_e    op;
        logic [11:0] addr;
        logic [63:0] operand;
        trap_e       trap;
        logic [63:0] pc;
    } csr_req_t;

    localparam logic [11:0] CSR_MSTATUS  = 12'h300;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;

    localparam logic [63:0] CAUSE_BREAKPOINT = 64'd3;
    localparam logic [63:0] CAUSE_ECALL_M    = 64'd11;

endpackage

// ==== design/wb_regfile.sv ====
module wb_regfile (
    input  logic            clk,
    input  logic            rst,
    input  wb_pkg::commit_t wr,
    input  logic [4:0]      rs1_addr,
    input  logic [4:0]      rs2_addr,
    output logic [63:0]     rs1_data,
    output logic [63:0]     rs2_data
);

    logic [63:0] regs [32];

    // one read port, with x0 pinned and the pending write bypassed.
    function automatic logic [63:0] read_port(input logic [4:0] addr,
                                              input logic [63:0] stored,
                                              input logic        we,
                                              input logic [4:0]  wr_rd,
                                              input logic [63:0] wr_data);
        logic [63:0] value;
        if (addr == 5'd0) begin
            value = 64'd0;
        end else if (we && (wr_rd == addr)) begin
            value = wr_data;
        end else begin
            value = stored;
        end
        return value;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 64'd0;
            end
        end else if (wr.we && (wr.rd != 5'd0)) begin
            regs[wr.rd] <= wr.data;
        end
    end

    assign rs1_data = read_port(rs1_addr, regs[rs1_addr], wr.we, wr.rd, wr.data);
    assign rs2_data = read_port(rs2_addr, regs[rs2_addr], wr.we, wr.rd, wr.data);

endmodule

// ==== design/wb_stage_reg.sv ====
module wb_stage_reg #(
    parameter logic [63:0] RESET_PC = 64'h0000_0000_8000_0000
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               enable,
    input  wb_pkg::wb_bundle_t d,
    output wb_pkg::wb_bundle_t q
);

    import wb_pkg::*;

    // the register comes out of reset holding a bubble, so nothing retires
    // until a real instruction has been loaded.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            q <= '{
                valid: 1'b0,
                trap:  TRAP_NOP,
                exe:   64'd0,
                mem:   64'd0,
                rd:    5'd0,
                rs1:   5'd0,
                csr:   12'd0,
                imm:   64'd0,
                zimm:  64'd0,
                pc:    RESET_PC,
                ctrl:  WB_NOP
            };
        end else if (enable) begin
            q <= d;
        end
        // with enable low the stage is stalled and keeps its instruction.
    end

    // a stray x on valid would leak into every commit downstream.
    a_valid_known : assert property (
        @(posedge clk) disable iff (rst) !$isunknown(q.valid)
    ) else $error("wb_stage_reg: q.valid is unknown");

endmodule

// ==== design/wb_top.sv ====
module wb_top #(
    parameter logic [63:0] RESET_PC    = 64'h0000_0000_8000_0000,
    parameter logic [63:0] MTVEC_RESET = 64'h0000_0000_8000_0100
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               enable,
    input  wb_pkg::wb_bundle_t stage_in,
    input  logic [4:0]         rs1_addr,
    input  logic [4:0]         rs2_addr,
    output logic [63:0]        rs1_data,
    output logic [63:0]        rs2_data,
    output wb_pkg::commit_t    commit_out,
    output wb_pkg::redirect_t  redirect
);

    import wb_pkg::*;

    wb_bundle_t  wb_q;     // instruction currently in writeback.
    csr_req_t    csr_req;
    logic [63:0] csr_rdata;

    wb_stage_reg #(
        .RESET_PC(RESET_PC)
    ) stage_reg_i (
        .clk    (clk),
        .rst    (rst),
        .enable (enable),
        .d      (stage_in),
        .q      (wb_q)
    );

    wb_commit commit_i (
        .enable     (enable),
        .wb         (wb_q),
        .csr_rdata  (csr_rdata),
        .csr_req    (csr_req),
        .commit_out (commit_out)
    );

    wb_csr_file #(
        .MTVEC_RESET(MTVEC_RESET)
    ) csr_file_i (
        .clk      (clk),
        .rst      (rst),
        .req      (csr_req),
        .rdata    (csr_rdata),
        .redirect (redirect)
    );

    wb_regfile regfile_i (
        .clk      (clk),
        .rst      (rst),
        .wr       (commit_out),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

endmodule

// ==== tests/wb_checker.sv ====
module wb_checker #(
    parameter logic [63:0] RESET_PC    = 64'h0000_0000_8000_0000,
    parameter logic [63:0] MTVEC_RESET = 64'h0000_0000_8000_0100
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               enable,
    input  wb_pkg::wb_bundle_t stage_in,
    input  logic [4:0]         rs1_addr,
    input  logic [4:0]         rs2_addr,
    input  logic [63:0]        rs1_data,
    input  logic [63:0]        rs2_data,
    input  wb_pkg::commit_t    commit_out,
    input  wb_pkg::redirect_t  redirect,
    output int                 error_count,
    output int                 check_count,
    output int                 commit_count,
    output int                 redirect_count
);

    import wb_pkg::*;

    wb_bundle_t  m_q;  // model of the instruction in writeback.
    logic [63:0] m_regs [32];
    logic [63:0] m_mstatus;
    logic [63:0] m_mtvec;
    logic [63:0] m_mepc;
    logic [63:0] m_mcause;
    logic [63:0] m_mscratch;

    initial begin
        error_count    = 0;
        check_count    = 0;
        commit_count   = 0;
        redirect_count = 0;
    end

    task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERR %0t: %s is %h, model expects %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [63:0] csr_read(input logic [11:0] addr);
        case (addr)
            CSR_MSTATUS:  return m_mstatus;
            CSR_MTVEC:    return m_mtvec;
            CSR_MEPC:     return m_mepc;
            CSR_MCAUSE:   return m_mcause;
            CSR_MSCRATCH: return m_mscratch;
            default:      return 64'd0;
        endcase
    endfunction

    task automatic csr_write(input logic [11:0] addr, input logic [63:0] value);
        case (addr)
            CSR_MSTATUS:  m_mstatus  = value;
            CSR_MTVEC:    m_mtvec    = value;
            CSR_MEPC:     m_mepc     = value;
            CSR_MCAUSE:   m_mcause   = value;
            CSR_MSCRATCH: m_mscratch = value;
            default: ;  // unknown csr, the write is dropped.
        endcase
    endtask

    task automatic reset_model();
        m_q      = '0;
        m_q.trap = TRAP_NOP;
        m_q.ctrl = WB_NOP;
        m_q.pc   = RESET_PC;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = 64'd0;
        end
        m_mstatus  = 64'd0;
        m_mtvec    = MTVEC_RESET;
        m_mepc     = 64'd0;
        m_mcause   = 64'd0;
        m_mscratch = 64'd0;
    endtask

    function automatic logic [63:0] model_read(input logic [4:0] addr, input logic we,
                                               input logic [63:0] data);
        if (addr == 5'd0) return 64'd0;
        if (we && m_q.rd == addr) return data;  // same-cycle write is visible.
        return m_regs[addr];
    endfunction

    // outputs settle after the rising edge, so each cycle is judged at the falling edge.
    always @(negedge clk) begin : check_cycle
        logic        retire;
        logic        exp_we;
        logic        exp_redirect;
        logic [63:0] old_csr;
        logic [63:0] operand;
        logic [63:0] exp_data;
        if (rst) reset_model();
        retire  = m_q.valid && enable && !rst;
        old_csr = csr_read(m_q.csr);
        case (m_q.ctrl)
            WB_EXE:  exp_data = m_q.exe;
            WB_MEM:  exp_data = m_q.mem;
            WB_IMM:  exp_data = m_q.imm;
            WB_PC4:  exp_data = m_q.pc + 64'd4;
            WB_NOP:  exp_data = 64'd0;
            default: exp_data = old_csr;
        endcase
        exp_we = retire && m_q.trap == TRAP_NOP && m_q.ctrl != WB_NOP && m_q.rd != 5'd0;
        compare("commit we", commit_out.we, exp_we);
        if (exp_we && commit_out.we) begin
            commit_count++;
            compare("commit rd", commit_out.rd, m_q.rd);
            compare("commit data", commit_out.data, exp_data);
        end
        exp_redirect = retire && m_q.trap != TRAP_NOP;
        compare("redirect valid", redirect.valid, exp_redirect);
        if (exp_redirect && redirect.valid) begin
            redirect_count++;
            compare("redirect pc", redirect.pc, (m_q.trap == TRAP_MRET) ? m_mepc : m_mtvec);
        end
        compare("rs1 data", rs1_data, model_read(rs1_addr, exp_we, exp_data));
        compare("rs2 data", rs2_data, model_read(rs2_addr, exp_we, exp_data));
        if (retire && m_q.trap == TRAP_NOP) begin
            operand = (m_q.ctrl inside {WB_CSRRWI, WB_CSRRSI, WB_CSRRCI}) ? m_q.zimm : m_q.exe;
            case (m_q.ctrl)
                WB_CSRRW, WB_CSRRWI: csr_write(m_q.csr, operand);
                WB_CSRRS, WB_CSRRSI: if (operand != 64'd0) csr_write(m_q.csr, old_csr | operand);
                WB_CSRRC, WB_CSRRCI: if (operand != 64'd0) csr_write(m_q.csr, old_csr & ~operand);
                default: ;
            endcase
        end
        if (retire && (m_q.trap == TRAP_ECALL || m_q.trap == TRAP_EBREAK)) begin
            m_mepc   = m_q.pc;
            m_mcause = (m_q.trap == TRAP_ECALL) ? 64'd11 : 64'd3;
        end
        if (exp_we) m_regs[m_q.rd] = exp_data;
        if (!rst && enable) m_q = stage_in;
    end

endmodule

// ==== tests/wb_tb.sv ====
module wb_tb;

    import wb_pkg::*;

    localparam logic [63:0] RESET_PC    = 64'h0000_0000_8000_0000;
    localparam logic [63:0] MTVEC_RESET = 64'h0000_0000_8000_0100;

    localparam int RESET_CYCLES    = 5;
    localparam int DIRECTED_CYCLES = 4;
    localparam int PHASE_CYCLES    = 400;
    localparam int MIX_CYCLES      = 1000;
    localparam int TOTAL_CYCLES    = RESET_CYCLES + DIRECTED_CYCLES + 4 * PHASE_CYCLES
                                     + MIX_CYCLES + 6;  // one spare cycle per test.

    logic        clk = 1'b0;
    logic        rst;
    logic        enable;
    wb_bundle_t  stage_in;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [63:0] rs1_data;
    logic [63:0] rs2_data;
    commit_t     commit_out;
    redirect_t   redirect;
    int          error_count;
    int          check_count;
    int          commit_count;
    int          redirect_count;
    int          test_count;
    logic [31:0] lcg_state;
    logic [4:0]  last_rd;

    always #5 clk = ~clk;

    wb_top #(.RESET_PC(RESET_PC), .MTVEC_RESET(MTVEC_RESET)) dut_i (
        .clk(clk), .rst(rst), .enable(enable), .stage_in(stage_in),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_data(rs1_data),
        .rs2_data(rs2_data), .commit_out(commit_out), .redirect(redirect)
    );

    wb_checker #(.RESET_PC(RESET_PC), .MTVEC_RESET(MTVEC_RESET)) check_i (
        .clk(clk), .rst(rst), .enable(enable), .stage_in(stage_in),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_data(rs1_data),
        .rs2_data(rs2_data), .commit_out(commit_out), .redirect(redirect),
        .error_count(error_count), .check_count(check_count),
        .commit_count(commit_count), .redirect_count(redirect_count)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic chance(input int pct);
        return ((next_random() >> 8) % 100) < pct;  // low lcg bits are weak.
    endfunction

    function automatic logic [63:0] random_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_random();
        lo = next_random();
        return {hi, lo};
    endfunction

    function automatic logic [11:0] pick_csr();
        case ((next_random() >> 8) % 6)
            0:       return CSR_MSTATUS;
            1:       return CSR_MTVEC;
            2:       return CSR_MEPC;
            3:       return CSR_MCAUSE;
            4:       return CSR_MSCRATCH;
            default: return 12'h7c0;
        endcase
    endfunction

    // mode 0 plain writeback, 1 csr ops, 2 anything, 3 a csrr of mtvec.
    task automatic make_bundle(input int valid_pct, input int trap_pct, input int mode,
                               output wb_bundle_t b);
        int sel;
        b       = '0;
        b.valid = chance(valid_pct);
        b.exe   = chance(25) ? 64'd0 : random_word();
        b.mem   = random_word();
        b.imm   = random_word();
        b.zimm  = chance(25) ? 64'd0 : 64'(next_random() >> 27);
        b.rd    = 5'(next_random() >> 11);
        b.rs1   = 5'(next_random() >> 11);
        b.csr   = pick_csr();
        b.pc    = 64'(next_random() & 32'hffff_fffc);
        sel     = (next_random() >> 8) % 11;
        case (mode)
            0:       b.ctrl = wb_ctrl_e'(sel % 5);
            1:       b.ctrl = wb_ctrl_e'(5 + sel % 6);
            default: b.ctrl = wb_ctrl_e'(sel);
        endcase
        if (chance(trap_pct)) b.trap = trap_e'(1 + (next_random() >> 8) % 3);
        if (mode == 3) begin
            b.ctrl = WB_CSRRS;
            b.csr  = CSR_MTVEC;
            b.exe  = 64'd0;
            b.rd   = b.rd | 5'd1;
        end
    endtask

    task automatic run_test(input string name, input int cycles, input int valid_pct,
                            input int enable_pct, input int trap_pct, input int mode);
        wb_bundle_t b;
        int         errors_before;
        errors_before = error_count;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            make_bundle(valid_pct, trap_pct, mode, b);
            stage_in <= b;
            enable   <= chance(enable_pct);
            // aiming rs1 at the instruction in writeback exercises the bypass.
            rs1_addr <= chance(25) ? last_rd : 5'(next_random() >> 11);
            rs2_addr <= 5'(next_random() >> 11);
            last_rd  = b.rd;
        end
        @(negedge clk);
        #1;
        test_count++;
        $display("test %-18s %0d cycles, %0d errors", name, cycles,
                 error_count - errors_before);
    endtask

    initial begin
        lcg_state  = 32'h6407be98;
        last_rd    = 5'd0;
        test_count = 0;
        rst        = 1'b1;
        enable     = 1'b0;
        stage_in   = '0;
        rs1_addr   = 5'd0;
        rs2_addr   = 5'd0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        run_test("mtvec_after_reset", DIRECTED_CYCLES, 100, 100, 0, 3);
        run_test("writeback_select", PHASE_CYCLES, 80, 100, 0, 0);
        run_test("stall", PHASE_CYCLES, 80, 40, 0, 0);
        run_test("csr_ops", PHASE_CYCLES, 80, 75, 0, 1);
        run_test("traps", PHASE_CYCLES, 80, 75, 30, 2);
        run_test("random_mix", MIX_CYCLES, 80, 75, 10, 2);
        $display("%0d tests, %0d checks, %0d commits, %0d redirects, %0d errors",
                 test_count, check_count, commit_count, redirect_count, error_count);
        if (error_count == 0 && commit_count > 0 && redirect_count > 0) begin
            $display("Result: PASSED");
        end else begin
            if (commit_count == 0) $display("no instruction was committed during the run");
            if (redirect_count == 0) $display("no trap redirect was seen during the run");
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(TOTAL_CYCLES * 20 + 500);
        $display("watchdog expired before the tests finished");
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== wb_writeback.f ====
design/wb_pkg.sv
design/wb_stage_reg.sv
design/wb_commit.sv
design/wb_csr_file.sv
design/wb_regfile.sv
design/wb_top.sv
tests/wb_checker.sv
tests/wb_tb.sv
